// ==== sim.f ====
hw/xr_pkg.sv
hw/xr_dp_ram.sv
hw/xr_ctrl_regs.sv
hw/xr_mem_arb.sv
hw/xr_subsys_top.sv
+incdir+testbench
testbench/tb_xr_subsys.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the XR subsystem testbench with Verilator
# exits nonzero when the build, the run or any check fails

cd "$(dirname "$0")" || exit 1

build_dir=build
log_file=${build_dir}/sim.log

if ! mkdir -p "${build_dir}"; then
    echo "could not create ${build_dir}"
    exit 1
fi

if ! verilator --binary --timing -f sim.f --top-module tb_xr_subsys \
        -Mdir "${build_dir}/obj_dir" -o tb_xr_subsys; then
    echo "verilator build failed"
    exit 1
fi

"${build_dir}/obj_dir/tb_xr_subsys" > "${log_file}" 2>&1
run_status=$?
cat "${log_file}"
if [ "${run_status}" -ne 0 ]; then
    echo "simulation exited with status ${run_status}"
    exit 1
fi

if grep -q "Test failed" "${log_file}"; then
    exit 1
fi
exit 0

// ==== testbench/tb_xr_checks.svh ====
/*
 * XR subsystem testbench checks
 *   error counters
 *   compare tasks for words, copper program entries and acknowledge levels
 *   host acknowledge wait with a cycle timeout
 *   included inside the testbench module after its signal declarations
 */

`ifndef TB_XR_CHECKS_SVH
`define TB_XR_CHECKS_SVH

int value_errors   = 0;
int timeout_errors = 0;

localparam int ACK_TIMEOUT = 50;

task automatic check_word(input string name, input xr_pkg::word_t got,
                          input xr_pkg::word_t exp);
    if (got !== exp) begin
        value_errors++;
        $display("[FAIL] %0t %s got %h expected %h", $time, name, got, exp);
    end
endtask

task automatic check_prog(input string name, input logic [31:0] got,
                          input logic [31:0] exp);
    if (got !== exp) begin
        value_errors++;
        $display("[FAIL] %0t %s got %h expected %h", $time, name, got, exp);
    end
endtask

task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
        value_errors++;
        $display("[FAIL] %0t %s got %b expected %b", $time, name, got, exp);
    end
endtask

// returns one drive delay after the edge that raised xr_ack_o
task automatic wait_host_ack(output logic seen);
    int cycles;
    seen   = 1'b0;
    cycles = 0;
    while (!seen && cycles < ACK_TIMEOUT) begin
        @(posedge clk);
        #DRIVE_DLY;
        cycles++;
        seen = (xr_ack_o === 1'b1);
    end
    if (!seen) begin
        timeout_errors++;
        $display("host request to address %h got no acknowledge within %0d cycles",
                 xr_req_i.addr, ACK_TIMEOUT);
    end
endtask

`endif

// ==== testbench/tb_xr_subsys.sv ====
/*
 * XR memory subsystem testbench
 *   clock, reset and DUT instance
 *   reference model of the control registers and memories
 *   stimulus table built from the model and applied in a loop
 */

`timescale 1ns/10ps

module tb_xr_subsys;

    // same sizes as the DUT defaults
    localparam int COLOR_W      = 8;
    localparam int TILE_W       = 12;
    localparam int TILE2_W      = 10;
    localparam int COPP_W       = 9;
    localparam int CLK_PERIOD   = 8;
    localparam int DRIVE_DLY    = 1;
    localparam int RESET_CYCLES = 10;
    localparam int STALL_CYCLES = 4;

    typedef enum logic [2:0] {OP_WR, OP_RD, OP_RACE, OP_VSTALL, OP_PROG} op_e;

    // caddr and cdata are the copper side of a race
    // in a video stall caddr is the host read address
    typedef struct packed {
        op_e           op;
        xr_pkg::addr_t addr;
        xr_pkg::word_t data;
        xr_pkg::addr_t caddr;
        xr_pkg::word_t cdata;
        logic [31:0]   exp_val;
    } step_t;

    logic               clk;
    logic               reset_i;
    logic               xr_sel_i;
    xr_pkg::xr_req_t    xr_req_i;
    logic               xr_ack_o;
    xr_pkg::word_t      xr_data_o;
    logic               copp_wr_sel_i;
    xr_pkg::addr_t      copp_wr_addr_i;
    xr_pkg::word_t      copp_wr_data_i;
    logic               copp_wr_ack_o;
    logic               vgen_color_sel_i;
    logic [COLOR_W-1:0] vgen_color_addr_i;
    xr_pkg::word_t      vgen_color_data_o;
    logic               vgen_tile_sel_i;
    logic [TILE_W-1:0]  vgen_tile_addr_i;
    xr_pkg::word_t      vgen_tile_data_o;
    logic               copp_prog_sel_i;
    logic [COPP_W-1:0]  copp_prog_addr_i;
    logic [31:0]        copp_prog_data_o;

    step_t         steps [$];
    xr_pkg::addr_t mem_addrs [$];
    integer        seed = 32'hd594_d2c2;

    xr_pkg::word_t reg_model [8];
    xr_pkg::word_t color_model [2**COLOR_W];
    xr_pkg::word_t tile_model [2**(TILE_W-1)];
    xr_pkg::word_t tile2_model [2**TILE2_W];
    xr_pkg::word_t copp_even_model [2**COPP_W];
    xr_pkg::word_t copp_odd_model [2**COPP_W];

    xr_subsys_top dut_i (
        .clk              (clk),
        .reset_i          (reset_i),
        .xr_sel_i         (xr_sel_i),
        .xr_req_i         (xr_req_i),
        .xr_ack_o         (xr_ack_o),
        .xr_data_o        (xr_data_o),
        .copp_wr_sel_i    (copp_wr_sel_i),
        .copp_wr_addr_i   (copp_wr_addr_i),
        .copp_wr_data_i   (copp_wr_data_i),
        .copp_wr_ack_o    (copp_wr_ack_o),
        .vgen_color_sel_i (vgen_color_sel_i),
        .vgen_color_addr_i(vgen_color_addr_i),
        .vgen_color_data_o(vgen_color_data_o),
        .vgen_tile_sel_i  (vgen_tile_sel_i),
        .vgen_tile_addr_i (vgen_tile_addr_i),
        .vgen_tile_data_o (vgen_tile_data_o),
        .copp_prog_sel_i  (copp_prog_sel_i),
        .copp_prog_addr_i (copp_prog_addr_i),
        .copp_prog_data_o (copp_prog_data_o)
    );

    `include "tb_xr_checks.svh"

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // bits 15..13 pick the XR region and bit 15 clear picks a register
    function automatic xr_pkg::word_t model_read(input xr_pkg::addr_t a);
        if (!a[15]) begin
            return (a[6:3] == 4'h0) ? reg_model[a[2:0]] : 16'h0000;
        end else if (a[15:13] == xr_pkg::XR_COLOR_MEM[15:13]) begin
            return color_model[a[COLOR_W-1:0]];
        end else if (a[15:13] == xr_pkg::XR_TILE_MEM[15:13]) begin
            return a[TILE_W-1] ? tile2_model[a[TILE2_W-1:0]] : tile_model[a[TILE_W-2:0]];
        end
        return a[0] ? copp_odd_model[a[COPP_W:1]] : copp_even_model[a[COPP_W:1]];
    endfunction

    function automatic void model_write(input xr_pkg::addr_t a, input xr_pkg::word_t d);
        if (!a[15]) begin
            if (a[6:3] == 4'h0) begin
                reg_model[a[2:0]] = d;
            end
        end else if (a[15:13] == xr_pkg::XR_COLOR_MEM[15:13]) begin
            color_model[a[COLOR_W-1:0]] = d;
        end else if (a[15:13] == xr_pkg::XR_TILE_MEM[15:13]) begin
            if (a[TILE_W-1]) begin
                tile2_model[a[TILE2_W-1:0]] = d;
            end else begin
                tile_model[a[TILE_W-2:0]] = d;
            end
        end else if (a[0]) begin
            copp_odd_model[a[COPP_W:1]] = d;
        end else begin
            copp_even_model[a[COPP_W:1]] = d;
        end
    endfunction

    function automatic xr_pkg::word_t next_data();
        logic [31:0] r;
        r = $random(seed);
        return r[15:0];
    endfunction

    // model is updated in table order, so reads carry the value expected at that point
    function automatic void add_step(input op_e op, input xr_pkg::addr_t a,
                                     input xr_pkg::addr_t ca);
        step_t s;
        s       = '0;
        s.op    = op;
        s.addr  = a;
        s.caddr = ca;
        s.data  = next_data();
        s.cdata = next_data();
        if (op == OP_WR || op == OP_RACE) begin
            model_write(a, s.data);
        end
        if (op == OP_RACE) begin
            model_write(ca, s.cdata);
        end
        if (op == OP_PROG) begin
            s.exp_val = {model_read({a[15:1], 1'b0}), model_read({a[15:1], 1'b1})};
        end else if (op == OP_VSTALL) begin
            // host word in the upper half, video word in the lower half
            s.exp_val = {model_read(ca), model_read(a)};
        end else begin
            s.exp_val = {16'h0000, model_read(a)};
        end
        steps.push_back(s);
    endfunction

    task automatic host_access(input logic wr, input xr_pkg::addr_t a,
                               input xr_pkg::word_t d, input xr_pkg::word_t exp);
        logic seen;
        xr_sel_i      = 1'b1;
        xr_req_i.wr   = wr;
        xr_req_i.addr = a;
        xr_req_i.data = d;
        wait_host_ack(seen);
        if (seen && !wr) begin
            check_word("xr_data_o", xr_data_o, exp);
        end
        xr_sel_i = 1'b0;
    endtask

    // copper and host ask for a write in the same cycle
    task automatic race_writes(input step_t s);
        logic copp_seen;
        logic host_seen;
        int   copp_cyc;
        int   host_cyc;
        int   cyc;
        copp_seen      = 1'b0;
        host_seen      = 1'b0;
        copp_cyc       = 0;
        host_cyc       = 0;
        cyc            = 0;
        copp_wr_sel_i  = 1'b1;
        copp_wr_addr_i = s.caddr;
        copp_wr_data_i = s.cdata;
        xr_sel_i       = 1'b1;
        xr_req_i.wr    = 1'b1;
        xr_req_i.addr  = s.addr;
        xr_req_i.data  = s.data;
        while (!(copp_seen && host_seen) && cyc < ACK_TIMEOUT) begin
            @(posedge clk);
            #DRIVE_DLY;
            cyc++;
            if (copp_wr_ack_o === 1'b1 && !copp_seen) begin
                check_bit("xr_ack_o", xr_ack_o, 1'b0);
                copp_seen     = 1'b1;
                copp_cyc      = cyc;
                copp_wr_sel_i = 1'b0;
            end
            if (xr_ack_o === 1'b1 && !host_seen) begin
                host_seen = 1'b1;
                host_cyc  = cyc;
                xr_sel_i  = 1'b0;
            end
        end
        copp_wr_sel_i = 1'b0;
        xr_sel_i      = 1'b0;
        if (!(copp_seen && host_seen)) begin
            timeout_errors++;
            $display("copper or host write was not acknowledged within %0d cycles",
                     ACK_TIMEOUT);
        end else if (host_cyc <= copp_cyc) begin
            value_errors++;
            $display("host write was acknowledged no later than the copper write at %0t",
                     $time);
        end
    endtask

    // video select held high stalls a host read of another word in the same memory
    task automatic video_stall(input step_t s);
        logic is_tile;
        logic seen;
        is_tile = (s.addr[15:13] == xr_pkg::XR_TILE_MEM[15:13]);
        if (is_tile) begin
            vgen_tile_sel_i  = 1'b1;
            vgen_tile_addr_i = s.addr[TILE_W-1:0];
        end else begin
            vgen_color_sel_i  = 1'b1;
            vgen_color_addr_i = s.addr[COLOR_W-1:0];
        end
        xr_sel_i      = 1'b1;
        xr_req_i.wr   = 1'b0;
        xr_req_i.addr = s.caddr;
        xr_req_i.data = '0;
        repeat (STALL_CYCLES) begin
            @(posedge clk);
            #DRIVE_DLY;
            check_bit("xr_ack_o", xr_ack_o, 1'b0);
            if (is_tile) begin
                check_word("vgen_tile_data_o", vgen_tile_data_o, s.exp_val[15:0]);
            end else begin
                check_word("vgen_color_data_o", vgen_color_data_o, s.exp_val[15:0]);
            end
        end
        vgen_tile_sel_i  = 1'b0;
        vgen_color_sel_i = 1'b0;
        wait_host_ack(seen);
        if (seen) begin
            check_word("xr_data_o", xr_data_o, s.exp_val[31:16]);
        end
        xr_sel_i = 1'b0;
    endtask

    task automatic prog_read(input xr_pkg::addr_t a, input logic [31:0] exp);
        copp_prog_sel_i  = 1'b1;
        copp_prog_addr_i = a[COPP_W:1];
        @(posedge clk);
        #DRIVE_DLY;
        check_prog("copp_prog_data_o", copp_prog_data_o, exp);
        copp_prog_sel_i = 1'b0;
    endtask

    initial begin
        reset_i           = 1'b1;
        xr_sel_i          = 1'b0;
        xr_req_i          = '0;
        copp_wr_sel_i     = 1'b0;
        copp_wr_addr_i    = '0;
        copp_wr_data_i    = '0;
        vgen_color_sel_i  = 1'b0;
        vgen_color_addr_i = '0;
        vgen_tile_sel_i   = 1'b0;
        vgen_tile_addr_i  = '0;
        copp_prog_sel_i   = 1'b0;
        copp_prog_addr_i  = '0;
        foreach (reg_model[i]) begin
            reg_model[i] = '0;
        end

        // registers read zero after reset, then write, then read the whole range
        for (int i = 0; i < 8; i++) begin
            add_step(OP_RD, 16'(i), '0);
        end
        for (int i = 0; i < 8; i++) begin
            add_step(OP_WR, 16'(i), '0);
        end
        add_step(OP_WR, 16'd8, '0);
        add_step(OP_WR, 16'd77, '0);
        add_step(OP_WR, 16'd127, '0);
        for (int i = 0; i < 128; i++) begin
            add_step(OP_RD, 16'(i), '0);
        end

        // colour, main tile, tile2 and both copper halves
        for (int i = 0; i < 4; i++) begin
            mem_addrs.push_back(xr_pkg::XR_COLOR_MEM | 16'(i * 37));
            mem_addrs.push_back(xr_pkg::XR_TILE_MEM | 16'(i * 301));
            mem_addrs.push_back(xr_pkg::XR_TILE_MEM | 16'h0800 | 16'(i * 157));
            mem_addrs.push_back(xr_pkg::XR_COPPER_MEM | 16'(2 * i));
            mem_addrs.push_back(xr_pkg::XR_COPPER_MEM | 16'(2 * i + 1));
        end
        foreach (mem_addrs[i]) begin
            add_step(OP_WR, mem_addrs[i], '0);
        end
        foreach (mem_addrs[i]) begin
            add_step(OP_RD, mem_addrs[i], '0);
        end

        add_step(OP_RACE, xr_pkg::XR_COLOR_MEM | 16'h0055, xr_pkg::XR_TILE_MEM | 16'h0844);
        add_step(OP_RACE, xr_pkg::XR_COPPER_MEM | 16'h0021, 16'h0003);
        add_step(OP_RD, xr_pkg::XR_COLOR_MEM | 16'h0055, '0);
        add_step(OP_RD, xr_pkg::XR_TILE_MEM | 16'h0844, '0);
        add_step(OP_RD, xr_pkg::XR_COPPER_MEM | 16'h0021, '0);
        add_step(OP_RD, 16'h0003, '0);

        // the host asks for a different word than the video side, tile across both halves
        add_step(OP_VSTALL, xr_pkg::XR_COLOR_MEM | 16'd37,
                 xr_pkg::XR_COLOR_MEM | 16'd74);
        add_step(OP_VSTALL, xr_pkg::XR_TILE_MEM | 16'd301,
                 xr_pkg::XR_TILE_MEM | 16'h0800 | 16'd157);
        add_step(OP_VSTALL, xr_pkg::XR_TILE_MEM | 16'h0800 | 16'd157,
                 xr_pkg::XR_TILE_MEM | 16'd602);
        for (int i = 0; i < 4; i++) begin
            add_step(OP_PROG, xr_pkg::XR_COPPER_MEM | 16'(2 * i), '0);
        end

        repeat (RESET_CYCLES) @(posedge clk);
        #DRIVE_DLY;
        reset_i = 1'b0;
        check_bit("xr_ack_o", xr_ack_o, 1'b0);
        check_bit("copp_wr_ack_o", copp_wr_ack_o, 1'b0);

        foreach (steps[i]) begin
            case (steps[i].op)
                OP_WR:     host_access(1'b1, steps[i].addr, steps[i].data, '0);
                OP_RD:     host_access(1'b0, steps[i].addr, '0, steps[i].exp_val[15:0]);
                OP_RACE:   race_writes(steps[i]);
                OP_VSTALL: video_stall(steps[i]);
                default:   prog_read(steps[i].addr, steps[i].exp_val);
            endcase
        end

        $display("errors: %0d wrong values, %0d timeouts", value_errors, timeout_errors);
        if (value_errors == 0 && timeout_errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// ==== hw/xr_subsys_top.sv ====
/*
 * XR memory subsystem top level
 *   memory arbiter with its RAMs
 *   control register file on the XR register bus
 *   sets the memory size parameters
 */

`timescale 1ns/10ps

module xr_subsys_top #(
    parameter int COLOR_W = 8,
    parameter int TILE_W  = 12,
    parameter int TILE2_W = 10,
    parameter int COPP_W  = 9
) (
    input  logic               clk,
    input  logic               reset_i,

    input  logic               xr_sel_i,
    input  xr_pkg::xr_req_t    xr_req_i,
    output logic               xr_ack_o,
    output xr_pkg::word_t      xr_data_o,

    input  logic               copp_wr_sel_i,
    input  xr_pkg::addr_t      copp_wr_addr_i,
    input  xr_pkg::word_t      copp_wr_data_i,
    output logic               copp_wr_ack_o,

    input  logic               vgen_color_sel_i,
    input  logic [COLOR_W-1:0] vgen_color_addr_i,
    output xr_pkg::word_t      vgen_color_data_o,

    input  logic               vgen_tile_sel_i,
    input  logic [TILE_W-1:0]  vgen_tile_addr_i,
    output xr_pkg::word_t      vgen_tile_data_o,

    input  logic               copp_prog_sel_i,
    input  logic [COPP_W-1:0]  copp_prog_addr_i,
    output logic [31:0]        copp_prog_data_o
);

    // register bus between arbiter and control registers
    logic          xreg_wr;
    logic [6:0]    xreg_addr;
    xr_pkg::word_t xreg_wr_data;
    xr_pkg::word_t xreg_rd_data;

    xr_mem_arb #(
        .COLOR_W(COLOR_W),
        .TILE_W (TILE_W),
        .TILE2_W(TILE2_W),
        .COPP_W (COPP_W)
    ) mem_arb_i (
        .clk              (clk),
        .reset_i          (reset_i),
        .xr_sel_i         (xr_sel_i),
        .xr_req_i         (xr_req_i),
        .xr_ack_o         (xr_ack_o),
        .xr_data_o        (xr_data_o),
        .copp_wr_sel_i    (copp_wr_sel_i),
        .copp_wr_addr_i   (copp_wr_addr_i),
        .copp_wr_data_i   (copp_wr_data_i),
        .copp_wr_ack_o    (copp_wr_ack_o),
        .vgen_color_sel_i (vgen_color_sel_i),
        .vgen_color_addr_i(vgen_color_addr_i),
        .vgen_color_data_o(vgen_color_data_o),
        .vgen_tile_sel_i  (vgen_tile_sel_i),
        .vgen_tile_addr_i (vgen_tile_addr_i),
        .vgen_tile_data_o (vgen_tile_data_o),
        .copp_prog_sel_i  (copp_prog_sel_i),
        .copp_prog_addr_i (copp_prog_addr_i),
        .copp_prog_data_o (copp_prog_data_o),
        .xreg_wr_o        (xreg_wr),
        .xreg_addr_o      (xreg_addr),
        .xreg_data_o      (xreg_wr_data),
        .xreg_data_i      (xreg_rd_data)
    );

    xr_ctrl_regs ctrl_regs_i (
        .clk        (clk),
        .reset_i    (reset_i),
        .xreg_wr_i  (xreg_wr),
        .xreg_addr_i(xreg_addr),
        .xreg_data_i(xreg_wr_data),
        .xreg_data_o(xreg_rd_data)
    );

endmodule

// ==== hw/xr_mem_arb.sv ====
/*
 * XR memory arbiter
 *   decodes host and copper XR addresses into regions
 *   copper writes win over host writes
 *   video and copper program reads win over host reads
 *   owns the colour, tile, tile2 and copper RAMs
 *   drives the XR register bus and returns host read data
 */

`timescale 1ns/10ps

module xr_mem_arb #(
    parameter int COLOR_W = 8,
    parameter int TILE_W  = 12,
    parameter int TILE2_W = 10,
    parameter int COPP_W  = 9
) (
    input  logic              clk,
    input  logic              reset_i,

    // host register interface
    input  logic              xr_sel_i,
    input  xr_pkg::xr_req_t   xr_req_i,
    output logic              xr_ack_o,
    output xr_pkg::word_t     xr_data_o,

    // copper write port
    input  logic              copp_wr_sel_i,
    input  xr_pkg::addr_t     copp_wr_addr_i,
    input  xr_pkg::word_t     copp_wr_data_i,
    output logic              copp_wr_ack_o,

    // video generator reads
    input  logic              vgen_color_sel_i,
    input  logic [COLOR_W-1:0] vgen_color_addr_i,
    output xr_pkg::word_t     vgen_color_data_o,
    input  logic              vgen_tile_sel_i,
    input  logic [TILE_W-1:0] vgen_tile_addr_i,
    output xr_pkg::word_t     vgen_tile_data_o,

    // copper program read, 32 bits per entry
    input  logic              copp_prog_sel_i,
    input  logic [COPP_W-1:0] copp_prog_addr_i,
    output logic [31:0]       copp_prog_data_o,

    // XR register bus
    output logic              xreg_wr_o,
    output logic [6:0]        xreg_addr_o,
    output xr_pkg::word_t     xreg_data_o,
    input  xr_pkg::word_t     xreg_data_i
);

    // host and copper region decode
    logic host_regs, host_color, host_tile, host_copp;
    logic cw_regs, cw_color, cw_tile, cw_copp;

    // pending host requests, none while the ack is out
    logic host_req;
    logic host_rd;

    // shared write path
    xr_pkg::addr_t wr_addr;
    xr_pkg::word_t wr_data;
    logic color_wr_en, tile_wr_en, copp_wr_en;
    logic copp_wr_ack_next, host_wr_ack_next;

    // read ports
    logic reg_rd_ack_next, color_rd_ack_next, tile_rd_ack_next, copp_rd_ack_next;
    logic                color_rd_en;
    logic [COLOR_W-1:0]  color_rd_addr;
    xr_pkg::word_t       color_rd_data;
    logic                tile_rd_en;
    logic [TILE_W-1:0]   tile_rd_addr;
    logic                tile_hi_q;
    xr_pkg::word_t       tile_rd_data;
    xr_pkg::word_t       tile2_rd_data;
    xr_pkg::word_t       tile_out;
    logic                copp_rd_en;
    logic [COPP_W-1:0]   copp_rd_addr;
    logic [31:0]         copp_rd_data;
    xr_pkg::word_t       reg_rd_q;

    assign host_regs  = ~xr_req_i.addr[15];
    assign host_color = (xr_req_i.addr[15:13] == xr_pkg::XR_COLOR_MEM[15:13]);
    assign host_tile  = (xr_req_i.addr[15:13] == xr_pkg::XR_TILE_MEM[15:13]);
    assign host_copp  = (xr_req_i.addr[15:13] == xr_pkg::XR_COPPER_MEM[15:13]);

    assign cw_regs  = ~copp_wr_addr_i[15];
    assign cw_color = (copp_wr_addr_i[15:13] == xr_pkg::XR_COLOR_MEM[15:13]);
    assign cw_tile  = (copp_wr_addr_i[15:13] == xr_pkg::XR_TILE_MEM[15:13]);
    assign cw_copp  = (copp_wr_addr_i[15:13] == xr_pkg::XR_COPPER_MEM[15:13]);

    assign host_req = xr_sel_i & ~xr_ack_o;
    assign host_rd  = host_req & ~xr_req_i.wr;

    // copper owns the write address and data whenever it is selecting
    assign wr_addr = copp_wr_sel_i ? copp_wr_addr_i : xr_req_i.addr;
    assign wr_data = copp_wr_sel_i ? copp_wr_data_i : xr_req_i.data;

    assign xreg_addr_o = wr_addr[6:0];
    assign xreg_data_o = wr_data;

    // write strobes
    always_comb begin
        copp_wr_ack_next = 1'b0;
        host_wr_ack_next = 1'b0;
        color_wr_en      = 1'b0;
        tile_wr_en       = 1'b0;
        copp_wr_en       = 1'b0;
        xreg_wr_o        = 1'b0;
        if (copp_wr_sel_i) begin
            if (!copp_wr_ack_o) begin
                copp_wr_ack_next = 1'b1;
                xreg_wr_o        = cw_regs;
                color_wr_en      = cw_color;
                tile_wr_en       = cw_tile;
                copp_wr_en       = cw_copp;
            end
        end else if (host_req && xr_req_i.wr) begin
            host_wr_ack_next = 1'b1;
            xreg_wr_o        = host_regs;
            color_wr_en      = host_color;
            tile_wr_en       = host_tile;
            copp_wr_en       = host_copp;
        end
    end

    // register reads wait while the copper holds the register bus address
    assign reg_rd_ack_next = host_rd & host_regs & ~copp_wr_sel_i;

    // colour read port, video first
    always_comb begin
        color_rd_en       = vgen_color_sel_i;
        color_rd_addr     = vgen_color_addr_i;
        color_rd_ack_next = 1'b0;
        if (!vgen_color_sel_i && host_rd && host_color) begin
            color_rd_en       = 1'b1;
            color_rd_addr     = xr_req_i.addr[COLOR_W-1:0];
            color_rd_ack_next = 1'b1;
        end
    end

    // tile read port, video first
    always_comb begin
        tile_rd_en       = vgen_tile_sel_i;
        tile_rd_addr     = vgen_tile_addr_i;
        tile_rd_ack_next = 1'b0;
        if (!vgen_tile_sel_i && host_rd && host_tile) begin
            tile_rd_en       = 1'b1;
            tile_rd_addr     = xr_req_i.addr[TILE_W-1:0];
            tile_rd_ack_next = 1'b1;
        end
    end

    // copper program read port, copper first
    always_comb begin
        copp_rd_en       = copp_prog_sel_i;
        copp_rd_addr     = copp_prog_addr_i;
        copp_rd_ack_next = 1'b0;
        if (!copp_prog_sel_i && host_rd && host_copp) begin
            copp_rd_en       = 1'b1;
            copp_rd_addr     = xr_req_i.addr[COPP_W:1];
            copp_rd_ack_next = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            xr_ack_o      <= 1'b0;
            copp_wr_ack_o <= 1'b0;
            tile_hi_q     <= 1'b0;
        end else begin
            copp_wr_ack_o <= copp_wr_ack_next;
            xr_ack_o      <= host_wr_ack_next | reg_rd_ack_next | color_rd_ack_next
                             | tile_rd_ack_next | copp_rd_ack_next;
            // remembers which tile RAM produced the current output word
            if (tile_rd_en) begin
                tile_hi_q <= tile_rd_addr[TILE_W-1];
            end
        end
    end

    // register read data captured at acceptance
    always_ff @(posedge clk) begin
        if (reg_rd_ack_next) begin
            reg_rd_q <= xreg_data_i;
        end
    end

    assign tile_out          = tile_hi_q ? tile2_rd_data : tile_rd_data;
    assign vgen_color_data_o = color_rd_data;
    assign vgen_tile_data_o  = tile_out;
    assign copp_prog_data_o  = copp_rd_data;

    // host read result, the request is still held during the ack cycle
    always_comb begin
        xr_data_o = reg_rd_q;
        if (host_color) begin
            xr_data_o = color_rd_data;
        end else if (host_tile) begin
            xr_data_o = tile_out;
        end else if (host_copp) begin
            xr_data_o = xr_req_i.addr[0] ? copp_rd_data[15:0] : copp_rd_data[31:16];
        end
    end

    xr_dp_ram #(
        .AWIDTH(COLOR_W),
        .DWIDTH(16)
    ) color_ram_i (
        .clk      (clk),
        .rd_en_i  (color_rd_en),
        .rd_addr_i(color_rd_addr),
        .rd_data_o(color_rd_data),
        .wr_en_i  (color_wr_en),
        .wr_addr_i(wr_addr[COLOR_W-1:0]),
        .wr_data_i(wr_data)
    );

    // main tile RAM, lower half of the tile region
    xr_dp_ram #(
        .AWIDTH(TILE_W-1),
        .DWIDTH(16)
    ) tile_ram_i (
        .clk      (clk),
        .rd_en_i  (tile_rd_en & ~tile_rd_addr[TILE_W-1]),
        .rd_addr_i(tile_rd_addr[TILE_W-2:0]),
        .rd_data_o(tile_rd_data),
        .wr_en_i  (tile_wr_en & ~wr_addr[TILE_W-1]),
        .wr_addr_i(wr_addr[TILE_W-2:0]),
        .wr_data_i(wr_data)
    );

    // tile2 RAM, upper half of the tile region
    xr_dp_ram #(
        .AWIDTH(TILE2_W),
        .DWIDTH(16)
    ) tile2_ram_i (
        .clk      (clk),
        .rd_en_i  (tile_rd_en & tile_rd_addr[TILE_W-1]),
        .rd_addr_i(tile_rd_addr[TILE2_W-1:0]),
        .rd_data_o(tile2_rd_data),
        .wr_en_i  (tile_wr_en & wr_addr[TILE_W-1]),
        .wr_addr_i(wr_addr[TILE2_W-1:0]),
        .wr_data_i(wr_data)
    );

    // copper even half holds bits 31..16
    xr_dp_ram #(
        .AWIDTH(COPP_W),
        .DWIDTH(16)
    ) copp_even_ram_i (
        .clk      (clk),
        .rd_en_i  (copp_rd_en),
        .rd_addr_i(copp_rd_addr),
        .rd_data_o(copp_rd_data[31:16]),
        .wr_en_i  (copp_wr_en & ~wr_addr[0]),
        .wr_addr_i(wr_addr[COPP_W:1]),
        .wr_data_i(wr_data)
    );

    xr_dp_ram #(
        .AWIDTH(COPP_W),
        .DWIDTH(16)
    ) copp_odd_ram_i (
        .clk      (clk),
        .rd_en_i  (copp_rd_en),
        .rd_addr_i(copp_rd_addr),
        .rd_data_o(copp_rd_data[15:0]),
        .wr_en_i  (copp_wr_en & wr_addr[0]),
        .wr_addr_i(wr_addr[COPP_W:1]),
        .wr_data_i(wr_data)
    );

endmodule

// ==== hw/xr_ctrl_regs.sv ====
/*
 * XR control registers
 *   eight word registers on the XR register bus
 *   synchronous write, combinational read
 *   addresses 8..127 read zero and ignore writes
 */

`timescale 1ns/10ps

module xr_ctrl_regs (
    input  logic          clk,
    input  logic          reset_i,
    input  logic          xreg_wr_i,
    input  logic [6:0]    xreg_addr_i,
    input  xr_pkg::word_t xreg_data_i,
    output xr_pkg::word_t xreg_data_o
);

    localparam int NUM_REGS = 8;

    xr_pkg::word_t regs [NUM_REGS];

    // only the low eight addresses are backed by storage
    logic addr_valid;
    logic [2:0] reg_idx;

    assign addr_valid = (xreg_addr_i[6:3] == 4'h0);
    assign reg_idx    = xreg_addr_i[2:0];

    always_ff @(posedge clk) begin
        if (reset_i) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (xreg_wr_i && addr_valid) begin
            regs[reg_idx] <= xreg_data_i;
        end
    end

    // read mux, unmapped addresses return zero
    always_comb begin
        xreg_data_o = '0;
        if (addr_valid) begin
            xreg_data_o = regs[reg_idx];
        end
    end

endmodule

// ==== hw/xr_dp_ram.sv ====
/*
 * Simple dual port block RAM
 *   one synchronous write port
 *   one read port with a registered output that holds when not enabled
 */

`timescale 1ns/10ps

module xr_dp_ram #(
    parameter int AWIDTH = 8,
    parameter int DWIDTH = 16
) (
    input  logic              clk,
    input  logic              rd_en_i,
    input  logic [AWIDTH-1:0] rd_addr_i,
    output logic [DWIDTH-1:0] rd_data_o,
    input  logic              wr_en_i,
    input  logic [AWIDTH-1:0] wr_addr_i,
    input  logic [DWIDTH-1:0] wr_data_i
);

    logic [DWIDTH-1:0] mem [2**AWIDTH];

    always_ff @(posedge clk) begin
        if (wr_en_i) begin
            mem[wr_addr_i] <= wr_data_i;
        end
    end

    // output keeps the last read word while rd_en_i is low
    always_ff @(posedge clk) begin
        if (rd_en_i) begin
            rd_data_o <= mem[rd_addr_i];
        end
    end

endmodule

// ==== hw/xr_pkg.sv ====
/*
 * XR memory block shared definitions
 *   word and address types
 *   base addresses of the XR memory regions
 *   host request struct
 */

package xr_pkg;

    // one data word on every XR port
    typedef logic [15:0] word_t;

    // one XR address
    typedef logic [15:0] addr_t;

    // region bases, a region is chosen by address bits 15..13
    // anything with bit 15 clear is a control register
    localparam addr_t XR_COLOR_MEM  = 16'h8000;
    localparam addr_t XR_TILE_MEM   = 16'hA000;
    localparam addr_t XR_COPPER_MEM = 16'hC000;

    // host request, held by the host until acknowledged
    typedef struct packed {
        // 1 for write, 0 for read
        logic  wr;
        addr_t addr;
        // write data, ignored on reads
        word_t data;
    } xr_req_t;

endpackage
